// ==== fp_adder.sv ====
// Single-precision add and subtract, three pipeline stages
// Align, add, then normalize. Truncates toward zero, denormals read as zero

module fp_adder (
    input  logic                   clock,
    input  logic                   reset,
    input  fp_alu_pkg::alu_issue_t issue,
    output fp_alu_pkg::alu_result_t result
);
    import fp_alu_pkg::*;

    logic        a_sign;
    logic        b_sign;
    logic [7:0]  a_exp;
    logic [7:0]  b_exp;
    logic [23:0] a_mant;
    logic [23:0] b_mant;
    logic        a_bigger;

    logic        s1_valid;
    reg_addr_t   s1_dest;
    logic        s1_sign;
    logic        s1_sub;
    logic [7:0]  s1_exp;
    logic [23:0] s1_big;
    logic [23:0] s1_small;

    logic        s2_valid;
    reg_addr_t   s2_dest;
    logic        s2_sign;
    logic [7:0]  s2_exp;
    logic [24:0] s2_sum;

    logic [4:0]  lead_zeros;
    logic [23:0] shifted;
    fp_word_t    norm_word;

    function automatic logic [4:0] count_leading_zeros(input logic [23:0] value);
        logic [4:0] count;
        logic       found;
        count = 5'd0;
        found = 1'b0;
        for (int i = 23; i >= 0; i--) begin
            if (value[i]) begin
                found = 1'b1;
            end else if (!found) begin
                count = count + 5'd1;
            end
        end
        return count;
    endfunction

    // Subtraction is an add with the sign of b flipped
    always_comb begin
        a_sign   = issue.operand_a[31];
        b_sign   = issue.operand_b[31] ^ (issue.opcode == OP_SUB);
        a_exp    = issue.operand_a[30:23];
        b_exp    = issue.operand_b[30:23];
        a_mant   = (a_exp == 8'd0) ? 24'd0 : {1'b1, issue.operand_a[22:0]};
        b_mant   = (b_exp == 8'd0) ? 24'd0 : {1'b1, issue.operand_b[22:0]};
        a_bigger = {a_exp, a_mant} >= {b_exp, b_mant};
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue.valid && (issue.opcode inside {OP_ADD, OP_SUB});
        end
        s1_dest <= issue.dest;
        s1_sub  <= a_sign ^ b_sign;
        // Larger magnitude goes first, shifted-out bits of the other are lost
        if (a_bigger) begin
            s1_sign  <= a_sign;
            s1_exp   <= a_exp;
            s1_big   <= a_mant;
            s1_small <= b_mant >> (a_exp - b_exp);
        end else begin
            s1_sign  <= b_sign;
            s1_exp   <= b_exp;
            s1_big   <= b_mant;
            s1_small <= a_mant >> (b_exp - a_exp);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
        s2_dest <= s1_dest;
        s2_sign <= s1_sign;
        s2_exp  <= s1_exp;
        s2_sum  <= s1_sub ? {1'b0, s1_big} - {1'b0, s1_small}
                          : {1'b0, s1_big} + {1'b0, s1_small};
    end

    // A carry shifts right by one, otherwise shift left past the leading zeros
    always_comb begin
        lead_zeros = count_leading_zeros(s2_sum[23:0]);
        shifted    = s2_sum[23:0] << lead_zeros;
        norm_word  = '0;
        if (s2_sum[24]) begin
            norm_word = {s2_sign, s2_exp + 8'd1, s2_sum[23:1]};
        end else if (s2_sum[23:0] != 24'd0 && s2_exp > {3'b000, lead_zeros}) begin
            norm_word = {s2_sign, s2_exp - {3'b000, lead_zeros}, shifted[22:0]};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= s2_valid;
        end
        result.dest <= s2_dest;
        result.data <= norm_word;
    end

endmodule

// ==== fp_alu.f ====
+incdir+.
fp_alu_pkg.sv
fp_alu_delay_line.sv
fp_adder.sv
fp_multiplier.sv
fp_logic_unit.sv
fp_saturator.sv
fp_alu.sv
fp_alu_clock_gen.sv
fp_alu_assertions.sv
fp_alu_tb.sv

// ==== fp_alu.sv ====
// Floating-point execution unit of the soft core
// Takes one issue per cycle and returns each result with its tag a fixed
// number of cycles later. No back-pressure in either direction
`include "fp_alu_params.svh"

module fp_alu (
    input  logic                   clock,
    input  logic                   reset,
    input  fp_alu_pkg::alu_issue_t issue,
    output fp_alu_pkg::alu_result_t result
);
    import fp_alu_pkg::*;

    localparam int ADD_LATENCY   = 3;
    localparam int MUL_LATENCY   = 2;
    localparam int LOGIC_LATENCY = 1;
    localparam int SAT_LATENCY   = 1;
    localparam int N_UNITS       = 5;

    alu_result_t add_result;
    alu_result_t mul_result;
    alu_result_t logic_result;
    alu_result_t sat_result;
    alu_result_t load_result;
    alu_result_t aligned [N_UNITS];

    fp_adder adder_i (
        .clock  (clock),
        .reset  (reset),
        .issue  (issue),
        .result (add_result)
    );

    fp_multiplier multiplier_i (
        .clock  (clock),
        .reset  (reset),
        .issue  (issue),
        .result (mul_result)
    );

    fp_logic_unit logic_unit_i (
        .clock  (clock),
        .reset  (reset),
        .issue  (issue),
        .result (logic_result)
    );

    fp_saturator saturator_i (
        .clock  (clock),
        .reset  (reset),
        .issue  (issue),
        .result (sat_result)
    );

    // Register load has no unit of its own, operand a goes straight to padding
    always_comb begin
        load_result.valid = issue.valid && (issue.opcode == OP_LDR);
        load_result.dest  = issue.dest;
        load_result.data  = issue.operand_a;
    end

    fp_alu_delay_line #(.STAGES(`FP_ALU_LATENCY - ADD_LATENCY)) add_align (
        .clock(clock), .reset(reset), .in_result(add_result), .out_result(aligned[0])
    );
    fp_alu_delay_line #(.STAGES(`FP_ALU_LATENCY - MUL_LATENCY)) mul_align (
        .clock(clock), .reset(reset), .in_result(mul_result), .out_result(aligned[1])
    );
    fp_alu_delay_line #(.STAGES(`FP_ALU_LATENCY - LOGIC_LATENCY)) logic_align (
        .clock(clock), .reset(reset), .in_result(logic_result), .out_result(aligned[2])
    );
    fp_alu_delay_line #(.STAGES(`FP_ALU_LATENCY - SAT_LATENCY)) sat_align (
        .clock(clock), .reset(reset), .in_result(sat_result), .out_result(aligned[3])
    );
    fp_alu_delay_line #(.STAGES(`FP_ALU_LATENCY)) load_align (
        .clock(clock), .reset(reset), .in_result(load_result), .out_result(aligned[4])
    );

    // Every path has the same depth, so at most one aligned valid is high
    always_comb begin
        result = '0;
        for (int i = 0; i < N_UNITS; i++) begin
            if (aligned[i].valid) begin
                result = aligned[i];
            end
        end
    end

endmodule

// ==== fp_alu_assertions.sv ====
// Result checks for the floating-point unit, bound into fp_alu by the testbench
// Expected results are rebuilt from the issue seen one pipeline depth earlier
`include "fp_alu_params.svh"

module fp_alu_assertions (
    input logic                    clock,
    input logic                    reset,
    input fp_alu_pkg::alu_issue_t  issue,
    input fp_alu_pkg::alu_result_t result
);
    import fp_alu_pkg::*;

    int          fail_count = 0;
    alu_issue_t  hist [`FP_ALU_LATENCY];
    alu_issue_t  old;
    longint      key_a;
    longint      key_b;
    fp_word_t    expected;
    alu_result_t expected_result;

    // Whole-number float to int, exact below 2^24
    function automatic int to_int(input fp_word_t f);
        int mag;
        int shift;
        mag   = int'({1'b1, f[22:0]});
        shift = int'(f[30:23]) - 150;
        mag   = (shift >= 0) ? (mag << shift) : (mag >> -shift);
        if (f[30:23] == 8'd0) mag = 0;
        return f[31] ? -mag : mag;
    endfunction

    function automatic fp_word_t to_single(input int value);
        int          mag;
        int          top;
        logic [31:0] norm;
        mag  = (value < 0) ? -value : value;
        top  = $clog2(mag + 1) - 1;
        norm = 32'(mag) << (23 - top);
        if (mag == 0) return '0;
        return {value[31], 8'(127 + top), norm[22:0]};
    endfunction

    // Larger floats get larger keys and both zeros land on 0
    function automatic longint order_key(input fp_word_t f);
        longint mag;
        mag = (f[30:23] == 8'd0) ? 64'sd0 : longint'(f[30:0]);
        return f[31] ? -mag : mag;
    endfunction

    // Issues sampled while reset is high never produce a result
    always_ff @(posedge clock) begin
        hist[0] <= issue;
        for (int i = 1; i < `FP_ALU_LATENCY; i++) begin
            hist[i] <= hist[i-1];
        end
        if (reset) begin
            for (int i = 0; i < `FP_ALU_LATENCY; i++) begin
                hist[i].valid <= 1'b0;
            end
        end
    end

    always_comb begin
        old   = hist[`FP_ALU_LATENCY-1];
        key_a = order_key(old.operand_a);
        key_b = order_key(old.operand_b);
        case (old.opcode)
            OP_ADD:    expected = to_single(to_int(old.operand_a) + to_int(old.operand_b));
            OP_SUB:    expected = to_single(to_int(old.operand_a) - to_int(old.operand_b));
            OP_MUL:    expected = to_single(to_int(old.operand_a) * to_int(old.operand_b));
            OP_AND:    expected = old.operand_a & old.operand_b;
            OP_OR:     expected = old.operand_a | old.operand_b;
            OP_NOT:    expected = ~old.operand_a;
            OP_POPCNT: expected = $countones(old.operand_a);
            OP_ABS:    expected = old.operand_a & 32'h7fff_ffff;
            OP_CMP_GT: expected = (key_a > key_b) ? '1 : '0;
            OP_CMP_EQ: expected = (key_a == key_b) ? '1 : '0;
            OP_SATP:   expected = (key_a > key_b) ? old.operand_b : old.operand_a;
            OP_SATN:   expected = (key_b > key_a) ? old.operand_b : old.operand_a;
            default:   expected = old.operand_a;
        endcase
        // An idle output is all zeros
        expected_result = '0;
        if (old.valid && old.opcode != OP_NOP) begin
            expected_result = '{1'b1, old.dest, expected};
        end
    end

    // Checked on the falling edge, where result and history have both settled
    reset_clears: assert property (@(negedge clock) reset |-> !result.valid)
        else begin
            fail_count++;
            $error("FAILED reset_clears expected valid 0 actual %b", result.valid);
        end

    result_matches: assert property (@(negedge clock) disable iff (reset)
        result == expected_result)
        else begin
            fail_count++;
            $error("FAILED %s expected %h actual %h",
                   old.opcode.name(), expected_result, result);
        end
endmodule

// ==== fp_alu_clock_gen.sv ====
// Clock and synchronous reset for the floating-point unit testbench
// Reset is held high for RESET_CYCLES rising edges and released on a falling edge
module fp_alu_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clock,
    output logic reset
);
    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end
endmodule

// ==== fp_alu_delay_line.sv ====
// Shift register for unit results, used to pad each unit to the common latency
// STAGES sets the number of added cycles, zero makes it a plain connection

module fp_alu_delay_line #(
    parameter int STAGES = 1
) (
    input  logic                    clock,
    input  logic                    reset,
    input  fp_alu_pkg::alu_result_t in_result,
    output fp_alu_pkg::alu_result_t out_result
);
    import fp_alu_pkg::*;

    generate
        if (STAGES == 0) begin : g_wire
            assign out_result = in_result;
        end else begin : g_regs
            alu_result_t stage_q [STAGES];

            always_ff @(posedge clock) begin
                stage_q[0] <= in_result;
                for (int i = 1; i < STAGES; i++) begin
                    stage_q[i] <= stage_q[i-1];
                end
                // Only the valids are cleared, data and dest just shift along
                if (reset) begin
                    for (int i = 0; i < STAGES; i++) begin
                        stage_q[i].valid <= 1'b0;
                    end
                end
            end

            assign out_result = stage_q[STAGES-1];
        end
    endgenerate

endmodule

// ==== fp_alu_params.svh ====
// Global sizes for the floating-point execution unit
// Included by the package and by any module that needs the pipeline depth

`ifndef FP_ALU_PARAMS_SVH
`define FP_ALU_PARAMS_SVH

// Operand and result word, one IEEE single or a raw bit pattern
`define FP_ALU_DATA_WIDTH 32

// Destination register address carried alongside every result
`define FP_ALU_REG_ADDR_WIDTH 8

// Cycles from the issue edge to the edge where the result is valid
// All units are padded to this depth
`define FP_ALU_LATENCY 5

`endif

// ==== fp_alu_pkg.sv ====
// Types shared by the floating-point execution unit
// Opcodes, issue and result words, and the float ordering used by compare and clamp
`include "fp_alu_params.svh"

package fp_alu_pkg;

    typedef logic [`FP_ALU_DATA_WIDTH-1:0]     fp_word_t;
    typedef logic [`FP_ALU_REG_ADDR_WIDTH-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        OP_NOP    = 4'd0,
        OP_ADD    = 4'd1,
        OP_SUB    = 4'd2,
        OP_MUL    = 4'd3,
        OP_AND    = 4'd4,
        OP_OR     = 4'd5,
        OP_NOT    = 4'd6,
        OP_POPCNT = 4'd7,
        OP_ABS    = 4'd8,
        OP_CMP_GT = 4'd9,
        OP_CMP_EQ = 4'd10,
        OP_SATP   = 4'd11,
        OP_SATN   = 4'd12,
        OP_LDR    = 4'd13
    } alu_opcode_t;

    typedef struct packed {
        logic        valid;
        alu_opcode_t opcode;
        reg_addr_t   dest;
        fp_word_t    operand_a;
        fp_word_t    operand_b;
    } alu_issue_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t dest;
        fp_word_t  data;
    } alu_result_t;

    // Magnitude with denormals flushed, so both zeros give 0
    function automatic logic [30:0] fp_magnitude(input fp_word_t value);
        return (value[30:23] == 8'd0) ? 31'd0 : value[30:0];
    endfunction

    function automatic logic fp_equal(input fp_word_t a, input fp_word_t b);
        return (fp_magnitude(a) == fp_magnitude(b)) &&
               ((a[31] == b[31]) || (fp_magnitude(a) == 31'd0));
    endfunction

    // Sign-magnitude order where +0 and -0 are the same value
    function automatic logic fp_greater(input fp_word_t a, input fp_word_t b);
        if (fp_magnitude(a) == 31'd0 && fp_magnitude(b) == 31'd0) begin
            return 1'b0;
        end
        case ({a[31], b[31]})
            2'b01:   return 1'b1;
            2'b10:   return 1'b0;
            2'b00:   return fp_magnitude(a) > fp_magnitude(b);
            default: return fp_magnitude(a) < fp_magnitude(b);
        endcase
    endfunction

endpackage

// ==== fp_alu_tb.sv ====
// Testbench top for the floating-point execution unit
// Drives directed, back-to-back and random issues while the bound checks compare results
`include "fp_alu_params.svh"

module fp_alu_tb;
    import fp_alu_pkg::*;

    localparam int SEED           = 95297;
    localparam int TIMEOUT_CYCLES = 400;
    localparam int RANDOM_ISSUES  = 200;

    logic        clock;
    logic        reset;
    alu_issue_t  issue;
    alu_result_t result;
    int          cycles;

    fp_alu_clock_gen #(.PERIOD(40), .RESET_CYCLES(10)) clock_gen_i (
        .clock (clock),
        .reset (reset)
    );

    fp_alu dut_i (
        .clock  (clock),
        .reset  (reset),
        .issue  (issue),
        .result (result)
    );

    bind fp_alu fp_alu_assertions checks_i (
        .clock  (clock),
        .reset  (reset),
        .issue  (issue),
        .result (result)
    );

    // Whole number of magnitude below 2^12 as a single, so sums and products are exact
    function automatic fp_word_t random_whole();
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] frac;
        sign = 1'($urandom);
        exp  = 8'($urandom_range(138, 126));
        frac = 23'($urandom) & ~(23'h7f_ffff >> (exp - 8'd127));
        if (exp == 8'd126) return {sign, 31'd0};
        return {sign, exp, frac};
    endfunction

    task automatic send(input logic valid, input alu_opcode_t opcode,
                        input fp_word_t a, input fp_word_t b);
        @(negedge clock);
        issue = '{valid, opcode, reg_addr_t'($urandom), a, b};
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clock);
            issue = '0;
        end
    endtask

    initial begin
        issue = '0;
        void'($urandom(SEED));
        // Valid issues during reset must all be dropped by the pipeline
        while (reset !== 1'b0) begin
            send(1'b1, alu_opcode_t'($urandom_range(13, 1)), random_whole(), random_whole());
            @(posedge clock);
        end
        send(1'b1, OP_NOP,    32'h3f80_0000, 32'h4000_0000);
        send(1'b1, OP_ADD,    32'h4040_0000, 32'h40a0_0000);
        send(1'b1, OP_ADD,    32'h4040_0000, 32'hc040_0000);  // 3 + -3 gives +0
        send(1'b1, OP_SUB,    32'h4000_0000, 32'h40a0_0000);
        send(1'b1, OP_MUL,    32'hc040_0000, 32'h457f_f000);  // -3 * 4095
        send(1'b1, OP_MUL,    32'h0000_0000, 32'hc0a0_0000);
        send(1'b0, OP_ADD,    32'h4040_0000, 32'h4040_0000);
        send(1'b1, OP_AND,    32'hf0f0_1234, 32'h0ff0_ff00);
        send(1'b1, OP_OR,     32'hf0f0_1234, 32'h0ff0_ff00);
        send(1'b1, OP_NOT,    32'h1234_5678, 32'h0000_0000);
        send(1'b1, OP_POPCNT, 32'hdead_beef, 32'h0000_0000);
        send(1'b1, OP_ABS,    32'hc040_0000, 32'h0000_0000);
        send(1'b1, OP_CMP_GT, 32'hc000_0000, 32'hc040_0000);
        send(1'b1, OP_CMP_GT, 32'h0000_0000, 32'h8000_0000);
        send(1'b1, OP_CMP_EQ, 32'h0000_0000, 32'h8000_0000);  // +0 equals -0
        send(1'b1, OP_CMP_EQ, 32'h4040_0000, 32'h4040_0000);
        send(1'b1, OP_CMP_EQ, 32'h4040_0000, 32'hc040_0000);  // 3 and -3 differ in sign only
        send(1'b1, OP_SATP,   32'h457f_f000, 32'h40a0_0000);
        send(1'b1, OP_SATN,   32'hc040_0000, 32'hc000_0000);
        send(1'b1, OP_LDR,    32'h1234_5678, 32'h0000_0000);
        idle(`FP_ALU_LATENCY + 1);
        // Every opcode in consecutive cycles
        for (int op = 1; op <= 13; op++) begin
            send(1'b1, alu_opcode_t'(op), random_whole(), random_whole());
        end
        repeat (RANDOM_ISSUES) begin
            send($urandom_range(3, 0) != 0, alu_opcode_t'($urandom_range(13, 0)),
                 random_whole(), random_whole());
        end
        idle(`FP_ALU_LATENCY + 2);
        if (dut_i.checks_i.fail_count == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("test failed");
            $fatal(1, "result checks reported errors");
        end
    end

    initial begin
        wait (dut_i.checks_i.fail_count != 0);
        $display("test failed");
        $fatal(1, "stopping at the first failed result check");
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycles++;
        end
        $display("test failed");
        $fatal(1, "Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    end
endmodule

// ==== fp_logic_unit.sv ====
// Bitwise operations, population count, absolute value and float compares
// One registered stage, compares return all ones for true

module fp_logic_unit (
    input  logic                   clock,
    input  logic                   reset,
    input  fp_alu_pkg::alu_issue_t issue,
    output fp_alu_pkg::alu_result_t result
);
    import fp_alu_pkg::*;

    fp_word_t logic_word;
    logic     is_logic_op;

    function automatic fp_word_t count_ones(input fp_word_t value);
        fp_word_t count;
        count = '0;
        for (int i = 0; i < $bits(fp_word_t); i++) begin
            count = count + fp_word_t'(value[i]);
        end
        return count;
    endfunction

    assign is_logic_op = issue.opcode inside {OP_AND, OP_OR, OP_NOT, OP_POPCNT,
                                              OP_ABS, OP_CMP_GT, OP_CMP_EQ};

    always_comb begin
        logic_word = '0;
        case (issue.opcode)
            OP_AND:    logic_word = issue.operand_a & issue.operand_b;
            OP_OR:     logic_word = issue.operand_a | issue.operand_b;
            OP_NOT:    logic_word = ~issue.operand_a;
            OP_POPCNT: logic_word = count_ones(issue.operand_a);
            // Clearing the sign bit is the float absolute value
            OP_ABS:    logic_word = {1'b0, issue.operand_a[30:0]};
            OP_CMP_GT: begin
                logic_word = fp_greater(issue.operand_a, issue.operand_b) ? '1 : '0;
            end
            OP_CMP_EQ: begin
                logic_word = fp_equal(issue.operand_a, issue.operand_b) ? '1 : '0;
            end
            default:   logic_word = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= issue.valid && is_logic_op;
        end
        result.dest <= issue.dest;
        result.data <= logic_word;
    end

endmodule

// ==== fp_multiplier.sv ====
// Single-precision multiply in two pipeline stages
// Product is truncated, zero operands and underflow give +0

module fp_multiplier (
    input  logic                   clock,
    input  logic                   reset,
    input  fp_alu_pkg::alu_issue_t issue,
    output fp_alu_pkg::alu_result_t result
);
    import fp_alu_pkg::*;

    logic [7:0]         a_exp;
    logic [7:0]         b_exp;
    logic [23:0]        a_mant;
    logic [23:0]        b_mant;

    logic               s1_valid;
    reg_addr_t          s1_dest;
    logic               s1_sign;
    logic               s1_zero;
    logic signed [9:0]  s1_exp;
    logic [47:0]        s1_prod;

    logic signed [9:0]  exp_adj;
    logic [22:0]        frac;
    fp_word_t           prod_word;

    always_comb begin
        a_exp  = issue.operand_a[30:23];
        b_exp  = issue.operand_b[30:23];
        a_mant = {1'b1, issue.operand_a[22:0]};
        b_mant = {1'b1, issue.operand_b[22:0]};
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue.valid && (issue.opcode == OP_MUL);
        end
        s1_dest <= issue.dest;
        s1_sign <= issue.operand_a[31] ^ issue.operand_b[31];
        s1_zero <= (a_exp == 8'd0) || (b_exp == 8'd0);
        s1_exp  <= {2'b00, a_exp} + {2'b00, b_exp} - 10'd127;
        s1_prod <= a_mant * b_mant;
    end

    // The product of two mantissas in [1,2) needs at most one position of shift
    always_comb begin
        exp_adj   = s1_exp + (s1_prod[47] ? 10'sd1 : 10'sd0);
        frac      = s1_prod[47] ? s1_prod[46:24] : s1_prod[45:23];
        prod_word = '0;
        if (!s1_zero && exp_adj > 10'sd0) begin
            prod_word = {s1_sign, exp_adj[7:0], frac};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= s1_valid;
        end
        result.dest <= s1_dest;
        result.data <= prod_word;
    end

endmodule

// ==== fp_saturator.sv ====
// Clamp of operand a against the limit in operand b, one registered stage
// OP_SATP keeps the lesser value, OP_SATN the greater

module fp_saturator (
    input  logic                   clock,
    input  logic                   reset,
    input  fp_alu_pkg::alu_issue_t issue,
    output fp_alu_pkg::alu_result_t result
);
    import fp_alu_pkg::*;

    fp_word_t clamped;

    // Same float order as the compare, so -0 and +0 never swap places
    always_comb begin
        clamped = issue.operand_a;
        if (issue.opcode == OP_SATP) begin
            if (fp_greater(issue.operand_a, issue.operand_b)) begin
                clamped = issue.operand_b;
            end
        end else if (fp_greater(issue.operand_b, issue.operand_a)) begin
            clamped = issue.operand_b;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= issue.valid && (issue.opcode inside {OP_SATP, OP_SATN});
        end
        result.dest <= issue.dest;
        result.data <= clamped;
    end

endmodule
